//--- test/axi_spill_mem_cases.txt
# op id addr len bp  (op: fl fill, wr/rd INCR, wx/rx FIXED, rw write and read together)
# id, addr and len in hex; bp 1 turns on random bready/rready
fl 0 0000 ff 0
wr 2 0040 00 0
rd 2 0040 00 0
wr 3 0100 07 0
wr 4 0110 03 0
rd 5 0100 07 0
wr 6 07f0 03 0
rd 6 07f0 01 0
rd 7 07f8 02 0
wx 8 0200 01 0
rd 8 0200 01 0
rx 9 0200 01 0
wr a 0300 0f 1
rd b 0300 0f 1
rw c 0080 05 1
rd e 0080 05 1

//--- sim.f
design/axi_pkg.sv
design/cc_stream_spill_reg.sv
design/axi_multistage_spill_reg.sv
design/axi_mem_sub.sv
design/axi_spill_mem_top.sv
test/axi_spill_mem_props.sv
test/tb_axi_spill_mem.sv

//--- test/tb_axi_spill_mem.sv
`timescale 1ns/100ps

module tb_axi_spill_mem;

  localparam int unsigned CASE_CYCLES = 256 + 40;

  typedef struct packed {
    logic [15:0]        op;
    axi_pkg::axi_id_t   id;
    axi_pkg::axi_addr_t addr;
    axi_pkg::axi_len_t  len;
    logic               bp;
  } case_t;

  logic             i_clk;
  logic             i_rst_n;
  axi_pkg::axi_aw_t i_aw;
  logic             i_awvalid;
  logic             o_awready;
  axi_pkg::axi_w_t  i_w;
  logic             i_wvalid;
  logic             o_wready;
  axi_pkg::axi_b_t  o_b;
  logic             o_bvalid;
  logic             i_bready;
  axi_pkg::axi_ar_t i_ar;
  logic             i_arvalid;
  logic             o_arready;
  axi_pkg::axi_r_t  o_r;
  logic             o_rvalid;
  logic             i_rready;

  axi_pkg::axi_data_t ref_mem [axi_pkg::MEM_WORDS];
  case_t              cases [$];
  logic [31:0]        lfsr_state;
  logic               use_bp;
  int unsigned        cycle_cnt;
  int unsigned        cycle_limit;

  axi_spill_mem_top u_dut (.*);

  always #20 i_clk = ~i_clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      abort_run("Timeout: the bursts did not finish within the cycle limit");
    end
  end

  // Bound handshake checks count their failures
  always @(posedge i_clk) begin
    if (u_dut.u_props.fail_count != 0) begin
      abort_run("A handshake assertion failed in the bound checker");
    end
  end

  // Right-shift Galois form, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'ha300_0000;
    return b;
  endfunction

  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v[i] = lfsr_bit();
    return v;
  endfunction

  function automatic logic ready_bit();
    return use_bp ? lfsr_bit() : 1'b1;
  endfunction

  // Any beat past the array or a non-INCR type fails the whole burst
  function automatic logic expect_err(input axi_pkg::axi_addr_t addr,
                                      input axi_pkg::axi_len_t len,
                                      input axi_pkg::axi_burst_e burst);
    return (int'(addr) / 8 + int'(len) >= axi_pkg::MEM_WORDS) ||
           (burst != axi_pkg::BURST_INCR);
  endfunction

  task automatic check_b(input axi_pkg::axi_b_t got, input axi_pkg::axi_b_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0d ns: o_b got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_r(input int beat, input axi_pkg::axi_r_t got, input axi_pkg::axi_r_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0d ns: o_r beat %0d got %h expected %h",
                          $time, beat, got, exp));
    end
  endtask

  task automatic write_burst(input axi_pkg::axi_id_t id, input axi_pkg::axi_addr_t addr,
                             input axi_pkg::axi_len_t len, input axi_pkg::axi_burst_e burst,
                             input logic full_strb);
    logic            err;
    axi_pkg::axi_w_t w;
    int              word;
    err = expect_err(addr, len, burst);
    @(negedge i_clk);
    i_aw = '{id: id, addr: addr, len: len, size: axi_pkg::SIZE_8B, burst: burst};
    i_awvalid = 1'b1;
    while (!o_awready) @(negedge i_clk);
    @(negedge i_clk);
    i_awvalid = 1'b0;
    for (int k = 0; k <= len; k++) begin
      w.data = lfsr_bits(64);
      w.strb = full_strb ? '1 : axi_pkg::axi_strb_t'(lfsr_bits(8));
      w.last = (k == len);
      i_w = w;
      i_wvalid = 1'b1;
      while (!o_wready) @(negedge i_clk);
      @(negedge i_clk);
      if (!err) begin
        word = int'(addr) / 8 + k;
        for (int b = 0; b < 8; b++) begin
          if (w.strb[b]) ref_mem[word][8*b +: 8] = w.data[8*b +: 8];
        end
      end
    end
    i_wvalid = 1'b0;
    i_bready = ready_bit();
    while (!(o_bvalid && i_bready)) begin
      @(negedge i_clk);
      i_bready = ready_bit();
    end
    check_b(o_b, '{id: id, resp: err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY});
    @(negedge i_clk);
    i_bready = 1'b0;
  endtask

  task automatic read_burst(input axi_pkg::axi_id_t id, input axi_pkg::axi_addr_t addr,
                            input axi_pkg::axi_len_t len, input axi_pkg::axi_burst_e burst);
    logic            err;
    axi_pkg::axi_r_t exp;
    err = expect_err(addr, len, burst);
    @(negedge i_clk);
    i_ar = '{id: id, addr: addr, len: len, size: axi_pkg::SIZE_8B, burst: burst};
    i_arvalid = 1'b1;
    while (!o_arready) @(negedge i_clk);
    @(negedge i_clk);
    i_arvalid = 1'b0;
    for (int k = 0; k <= len; k++) begin
      i_rready = ready_bit();
      while (!(o_rvalid && i_rready)) begin
        @(negedge i_clk);
        i_rready = ready_bit();
      end
      exp.id   = id;
      exp.resp = err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
      exp.last = (k == len);
      if (err) exp.data = '0;
      else exp.data = ref_mem[int'(addr) / 8 + k];
      check_r(k, o_r, exp);
      @(negedge i_clk);
    end
    i_rready = 1'b0;
  endtask

  initial begin : main
    int                 fd;
    int                 bp;
    string              line;
    logic [15:0]        op;
    axi_pkg::axi_id_t   id;
    axi_pkg::axi_addr_t addr;
    axi_pkg::axi_len_t  len;
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_aw        = '0;
    i_awvalid   = 1'b0;
    i_w         = '0;
    i_wvalid    = 1'b0;
    i_bready    = 1'b0;
    i_ar        = '0;
    i_arvalid   = 1'b0;
    i_rready    = 1'b0;
    lfsr_state  = 32'hbb39f444;
    use_bp      = 1'b0;
    cycle_cnt   = 0;
    cycle_limit = 0;

    fd = $fopen("test/axi_spill_mem_cases.txt", "r");
    if (fd == 0) abort_run("Could not open the case file test/axi_spill_mem_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%s %h %h %h %d", op, id, addr, len, bp) == 5) begin
          cases.push_back('{op: op, id: id, addr: addr, len: len, bp: bp[0]});
        end
      end
    end
    $fclose(fd);
    cycle_limit = cases.size() * CASE_CYCLES;

    repeat (4) @(negedge i_clk);
    i_rst_n = 1'b1;

    foreach (cases[i]) begin
      use_bp = cases[i].bp;
      case (cases[i].op)
        "fl": write_burst(cases[i].id, cases[i].addr, cases[i].len, axi_pkg::BURST_INCR, 1'b1);
        "wr": write_burst(cases[i].id, cases[i].addr, cases[i].len, axi_pkg::BURST_INCR, 1'b0);
        "wx": write_burst(cases[i].id, cases[i].addr, cases[i].len, axi_pkg::BURST_FIXED, 1'b0);
        "rd": read_burst(cases[i].id, cases[i].addr, cases[i].len, axi_pkg::BURST_INCR);
        "rx": read_burst(cases[i].id, cases[i].addr, cases[i].len, axi_pkg::BURST_FIXED);
        // Read side uses a disjoint region and the next id
        "rw": fork
          write_burst(cases[i].id, cases[i].addr, cases[i].len, axi_pkg::BURST_INCR, 1'b0);
          read_burst(cases[i].id + 4'h1, cases[i].addr ^ 16'h0400, cases[i].len,
                     axi_pkg::BURST_INCR);
        join
        default: abort_run($sformatf("Unknown operation %s in the case file", cases[i].op));
      endcase
    end

    repeat (2) @(negedge i_clk);
    if (u_dut.u_props.fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run("Handshake assertions failed during the run");
    end
  end

endmodule

//--- test/axi_spill_mem_props.sv
`timescale 1ns/100ps

module axi_spill_mem_props (
  input wire              i_clk,
  input wire              i_rst_n,
  input axi_pkg::axi_ar_t i_ar,
  input logic             i_arvalid,
  input logic             o_arready,
  input axi_pkg::axi_b_t  o_b,
  input logic             o_bvalid,
  input logic             i_bready,
  input axi_pkg::axi_r_t  o_r,
  input logic             o_rvalid,
  input logic             i_rready
);

  axi_pkg::axi_len_t rd_len;
  axi_pkg::axi_len_t beat_cnt;
  int unsigned       fail_count = 0;

  // Length of the read in flight, one read at a time
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_len   <= '0;
      beat_cnt <= '0;
    end else begin
      if (i_arvalid && o_arready) rd_len <= i_ar.len;
      if (o_rvalid && i_rready) beat_cnt <= o_r.last ? '0 : beat_cnt + 1'b1;
    end
  end

  a_b_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_b))
    else begin
      $error("B response dropped or changed before bready");
      fail_count = fail_count + 1;
    end

  a_r_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_r))
    else begin
      $error("R beat dropped or changed before rready");
      fail_count = fail_count + 1;
    end

  a_r_last: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_rvalid |-> (o_r.last == (beat_cnt == rd_len)))
    else begin
      $error("rlast not on the final beat");
      fail_count = fail_count + 1;
    end

  a_reset_idle: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !o_bvalid && !o_rvalid)
    else begin
      $error("Response valid high right after reset");
      fail_count = fail_count + 1;
    end

endmodule

bind axi_spill_mem_top axi_spill_mem_props u_props (.*);

//--- design/axi_spill_mem_top.sv
`timescale 1ns/100ps

module axi_spill_mem_top (
  input  wire              i_clk,
  input  wire              i_rst_n,
  input  axi_pkg::axi_aw_t i_aw,
  input  logic             i_awvalid,
  output logic             o_awready,
  input  axi_pkg::axi_w_t  i_w,
  input  logic             i_wvalid,
  output logic             o_wready,
  output axi_pkg::axi_b_t  o_b,
  output logic             o_bvalid,
  input  logic             i_bready,
  input  axi_pkg::axi_ar_t i_ar,
  input  logic             i_arvalid,
  output logic             o_arready,
  output axi_pkg::axi_r_t  o_r,
  output logic             o_rvalid,
  input  logic             i_rready
);

  axi_pkg::axi_aw_t mem_aw;
  logic             mem_awvalid;
  logic             mem_awready;
  axi_pkg::axi_w_t  mem_w;
  logic             mem_wvalid;
  logic             mem_wready;
  axi_pkg::axi_b_t  mem_b;
  logic             mem_bvalid;
  logic             mem_bready;
  axi_pkg::axi_ar_t mem_ar;
  logic             mem_arvalid;
  logic             mem_arready;
  axi_pkg::axi_r_t  mem_r;
  logic             mem_rvalid;
  logic             mem_rready;

  // B path left as a bypass
  axi_multistage_spill_reg #(
    .NUM_STAGES_AW(axi_pkg::NUM_STAGES_DEFAULT),
    .NUM_STAGES_W (axi_pkg::NUM_STAGES_DEFAULT),
    .NUM_STAGES_B (0),
    .NUM_STAGES_AR(axi_pkg::NUM_STAGES_DEFAULT),
    .NUM_STAGES_R (axi_pkg::NUM_STAGES_DEFAULT)
  ) u_stages (
    .i_clk, .i_rst_n,
    .i_s_aw(i_aw), .i_s_awvalid(i_awvalid), .o_s_awready(o_awready),
    .i_s_w (i_w),  .i_s_wvalid (i_wvalid),  .o_s_wready (o_wready),
    .o_s_b (o_b),  .o_s_bvalid (o_bvalid),  .i_s_bready (i_bready),
    .i_s_ar(i_ar), .i_s_arvalid(i_arvalid), .o_s_arready(o_arready),
    .o_s_r (o_r),  .o_s_rvalid (o_rvalid),  .i_s_rready (i_rready),
    .o_m_aw(mem_aw), .o_m_awvalid(mem_awvalid), .i_m_awready(mem_awready),
    .o_m_w (mem_w),  .o_m_wvalid (mem_wvalid),  .i_m_wready (mem_wready),
    .i_m_b (mem_b),  .i_m_bvalid (mem_bvalid),  .o_m_bready (mem_bready),
    .o_m_ar(mem_ar), .o_m_arvalid(mem_arvalid), .i_m_arready(mem_arready),
    .i_m_r (mem_r),  .i_m_rvalid (mem_rvalid),  .o_m_rready (mem_rready)
  );

  axi_mem_sub u_mem (
    .i_clk, .i_rst_n,
    .i_aw(mem_aw), .i_awvalid(mem_awvalid), .o_awready(mem_awready),
    .i_w (mem_w),  .i_wvalid (mem_wvalid),  .o_wready (mem_wready),
    .o_b (mem_b),  .o_bvalid (mem_bvalid),  .i_bready (mem_bready),
    .i_ar(mem_ar), .i_arvalid(mem_arvalid), .o_arready(mem_arready),
    .o_r (mem_r),  .o_rvalid (mem_rvalid),  .i_rready (mem_rready)
  );

endmodule

//--- design/axi_mem_sub.sv
`timescale 1ns/100ps

module axi_mem_sub (
  input  wire              i_clk,
  input  wire              i_rst_n,
  input  axi_pkg::axi_aw_t i_aw,
  input  logic             i_awvalid,
  output logic             o_awready,
  input  axi_pkg::axi_w_t  i_w,
  input  logic             i_wvalid,
  output logic             o_wready,
  output axi_pkg::axi_b_t  o_b,
  output logic             o_bvalid,
  input  logic             i_bready,
  input  axi_pkg::axi_ar_t i_ar,
  input  logic             i_arvalid,
  output logic             o_arready,
  output axi_pkg::axi_r_t  o_r,
  output logic             o_rvalid,
  input  logic             i_rready
);

  axi_pkg::axi_data_t mem [axi_pkg::MEM_WORDS];

  axi_pkg::mem_wr_state_e                wr_state;
  axi_pkg::axi_id_t                      wr_id;
  logic [$clog2(axi_pkg::MEM_WORDS)-1:0] wr_word;
  axi_pkg::axi_len_t                     wr_cnt;
  logic                                  wr_err;
  logic                                  w_last;

  axi_pkg::mem_rd_state_e                rd_state;
  axi_pkg::axi_id_t                      rd_id;
  logic [$clog2(axi_pkg::MEM_WORDS)-1:0] rd_word;
  logic [$clog2(axi_pkg::MEM_WORDS)-1:0] rd_fetch;
  axi_pkg::axi_len_t                     rd_cnt;
  logic                                  rd_err;
  logic                                  ar_err;
  axi_pkg::axi_data_t                    rd_data;

  // Out of range, narrow or non-INCR bursts fail as a whole
  function automatic logic burst_err(
    input axi_pkg::axi_addr_t  addr,
    input axi_pkg::axi_len_t   len,
    input axi_pkg::axi_size_e  size,
    input axi_pkg::axi_burst_e burst
  );
    logic [$bits(axi_pkg::axi_addr_t):0] last_word;
    last_word = addr >> 3;
    last_word = last_word + len;
    return (last_word >= axi_pkg::MEM_WORDS) || (size != axi_pkg::SIZE_8B) ||
           (burst != axi_pkg::BURST_INCR);
  endfunction

  assign o_awready = (wr_state == axi_pkg::WR_IDLE);
  assign o_wready  = (wr_state == axi_pkg::WR_DATA);
  assign o_bvalid  = (wr_state == axi_pkg::WR_RESP);
  assign o_b       = '{id: wr_id, resp: wr_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY};
  // Burst ends on the last flag or when the count runs out
  assign w_last    = i_w.last || (wr_cnt == '0);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_state <= axi_pkg::WR_IDLE;
      wr_id    <= '0;
      wr_word  <= '0;
      wr_cnt   <= '0;
      wr_err   <= 1'b0;
    end else begin
      unique case (wr_state)
        axi_pkg::WR_IDLE: begin
          if (i_awvalid) begin
            wr_state <= axi_pkg::WR_DATA;
            wr_id    <= i_aw.id;
            wr_word  <= i_aw.addr[3 +: $clog2(axi_pkg::MEM_WORDS)];
            wr_cnt   <= i_aw.len;
            wr_err   <= burst_err(i_aw.addr, i_aw.len, i_aw.size, i_aw.burst);
          end
        end
        axi_pkg::WR_DATA: begin
          if (i_wvalid) begin
            wr_word <= wr_word + 1'b1;
            wr_cnt  <= wr_cnt - 1'b1;
            if (w_last) wr_state <= axi_pkg::WR_RESP;
          end
        end
        axi_pkg::WR_RESP: begin
          if (i_bready) wr_state <= axi_pkg::WR_IDLE;
        end
        default: wr_state <= axi_pkg::WR_IDLE;
      endcase
    end
  end

  // Byte lane writes
  always_ff @(posedge i_clk) begin
    if (o_wready && i_wvalid && !wr_err) begin
      for (int b = 0; b < $bits(axi_pkg::axi_strb_t); b++) begin
        if (i_w.strb[b]) mem[wr_word][8*b +: 8] <= i_w.data[8*b +: 8];
      end
    end
  end

  assign ar_err    = burst_err(i_ar.addr, i_ar.len, i_ar.size, i_ar.burst);
  assign o_arready = (rd_state == axi_pkg::RD_IDLE);
  assign o_rvalid  = (rd_state == axi_pkg::RD_DATA);
  assign o_r       = '{id: rd_id, data: rd_data,
                       resp: rd_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY,
                       last: rd_cnt == '0};
  // Word for the next beat on the R channel
  assign rd_fetch  = o_arready ? i_ar.addr[3 +: $clog2(axi_pkg::MEM_WORDS)] : rd_word + 1'b1;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_state <= axi_pkg::RD_IDLE;
      rd_id    <= '0;
      rd_word  <= '0;
      rd_cnt   <= '0;
      rd_err   <= 1'b0;
    end else if (o_arready && i_arvalid) begin
      rd_state <= axi_pkg::RD_DATA;
      rd_id    <= i_ar.id;
      rd_word  <= rd_fetch;
      rd_cnt   <= i_ar.len;
      rd_err   <= ar_err;
    end else if (o_rvalid && i_rready) begin
      if (rd_cnt == '0) rd_state <= axi_pkg::RD_IDLE;
      rd_word <= rd_fetch;
      rd_cnt  <= rd_cnt - 1'b1;
    end
  end

  // Data stays put while rready is low
  always_ff @(posedge i_clk) begin
    if (o_arready && i_arvalid) begin
      rd_data <= ar_err ? '0 : mem[rd_fetch];
    end else if (o_rvalid && i_rready && rd_cnt != '0) begin
      rd_data <= rd_err ? '0 : mem[rd_fetch];
    end
  end

endmodule

//--- design/axi_multistage_spill_reg.sv
`timescale 1ns/100ps

module axi_multistage_spill_reg #(
  parameter int unsigned NUM_STAGES_AW = axi_pkg::NUM_STAGES_DEFAULT,
  parameter int unsigned NUM_STAGES_W  = axi_pkg::NUM_STAGES_DEFAULT,
  parameter int unsigned NUM_STAGES_B  = axi_pkg::NUM_STAGES_DEFAULT,
  parameter int unsigned NUM_STAGES_AR = axi_pkg::NUM_STAGES_DEFAULT,
  parameter int unsigned NUM_STAGES_R  = axi_pkg::NUM_STAGES_DEFAULT
) (
  input  wire              i_clk,
  input  wire              i_rst_n,
  // Subordinate side
  input  axi_pkg::axi_aw_t i_s_aw,
  input  logic             i_s_awvalid,
  output logic             o_s_awready,
  input  axi_pkg::axi_w_t  i_s_w,
  input  logic             i_s_wvalid,
  output logic             o_s_wready,
  output axi_pkg::axi_b_t  o_s_b,
  output logic             o_s_bvalid,
  input  logic             i_s_bready,
  input  axi_pkg::axi_ar_t i_s_ar,
  input  logic             i_s_arvalid,
  output logic             o_s_arready,
  output axi_pkg::axi_r_t  o_s_r,
  output logic             o_s_rvalid,
  input  logic             i_s_rready,
  // Manager side
  output axi_pkg::axi_aw_t o_m_aw,
  output logic             o_m_awvalid,
  input  logic             i_m_awready,
  output axi_pkg::axi_w_t  o_m_w,
  output logic             o_m_wvalid,
  input  logic             i_m_wready,
  input  axi_pkg::axi_b_t  i_m_b,
  input  logic             i_m_bvalid,
  output logic             o_m_bready,
  output axi_pkg::axi_ar_t o_m_ar,
  output logic             o_m_arvalid,
  input  logic             i_m_arready,
  input  axi_pkg::axi_r_t  i_m_r,
  input  logic             i_m_rvalid,
  output logic             o_m_rready
);

  axi_pkg::axi_aw_t aw_data  [axi_pkg::num_spill_regs(NUM_STAGES_AW)+1];
  logic             aw_valid [axi_pkg::num_spill_regs(NUM_STAGES_AW)+1];
  logic             aw_ready [axi_pkg::num_spill_regs(NUM_STAGES_AW)+1];
  axi_pkg::axi_w_t  w_data   [axi_pkg::num_spill_regs(NUM_STAGES_W)+1];
  logic             w_valid  [axi_pkg::num_spill_regs(NUM_STAGES_W)+1];
  logic             w_ready  [axi_pkg::num_spill_regs(NUM_STAGES_W)+1];
  axi_pkg::axi_b_t  b_data   [axi_pkg::num_spill_regs(NUM_STAGES_B)+1];
  logic             b_valid  [axi_pkg::num_spill_regs(NUM_STAGES_B)+1];
  logic             b_ready  [axi_pkg::num_spill_regs(NUM_STAGES_B)+1];
  axi_pkg::axi_ar_t ar_data  [axi_pkg::num_spill_regs(NUM_STAGES_AR)+1];
  logic             ar_valid [axi_pkg::num_spill_regs(NUM_STAGES_AR)+1];
  logic             ar_ready [axi_pkg::num_spill_regs(NUM_STAGES_AR)+1];
  axi_pkg::axi_r_t  r_data   [axi_pkg::num_spill_regs(NUM_STAGES_R)+1];
  logic             r_valid  [axi_pkg::num_spill_regs(NUM_STAGES_R)+1];
  logic             r_ready  [axi_pkg::num_spill_regs(NUM_STAGES_R)+1];

  // Requests run subordinate to manager
  assign aw_data[0]  = i_s_aw;
  assign aw_valid[0] = i_s_awvalid;
  assign o_s_awready = aw_ready[0];
  for (genvar i = 0; i < axi_pkg::num_spill_regs(NUM_STAGES_AW); i++) begin : g_aw_stages
    cc_stream_spill_reg #(.data_t(axi_pkg::axi_aw_t), .BYPASS(NUM_STAGES_AW == 0)) u_spill_aw (
      .i_clk, .i_rst_n,
      .i_valid(aw_valid[i]),   .i_data(aw_data[i]),   .o_ready(aw_ready[i]),
      .o_valid(aw_valid[i+1]), .o_data(aw_data[i+1]), .i_ready(aw_ready[i+1])
    );
  end
  assign o_m_aw      = aw_data[axi_pkg::num_spill_regs(NUM_STAGES_AW)];
  assign o_m_awvalid = aw_valid[axi_pkg::num_spill_regs(NUM_STAGES_AW)];
  assign aw_ready[axi_pkg::num_spill_regs(NUM_STAGES_AW)] = i_m_awready;

  assign w_data[0]  = i_s_w;
  assign w_valid[0] = i_s_wvalid;
  assign o_s_wready = w_ready[0];
  for (genvar i = 0; i < axi_pkg::num_spill_regs(NUM_STAGES_W); i++) begin : g_w_stages
    cc_stream_spill_reg #(.data_t(axi_pkg::axi_w_t), .BYPASS(NUM_STAGES_W == 0)) u_spill_w (
      .i_clk, .i_rst_n,
      .i_valid(w_valid[i]),   .i_data(w_data[i]),   .o_ready(w_ready[i]),
      .o_valid(w_valid[i+1]), .o_data(w_data[i+1]), .i_ready(w_ready[i+1])
    );
  end
  assign o_m_w      = w_data[axi_pkg::num_spill_regs(NUM_STAGES_W)];
  assign o_m_wvalid = w_valid[axi_pkg::num_spill_regs(NUM_STAGES_W)];
  assign w_ready[axi_pkg::num_spill_regs(NUM_STAGES_W)] = i_m_wready;

  assign ar_data[0]  = i_s_ar;
  assign ar_valid[0] = i_s_arvalid;
  assign o_s_arready = ar_ready[0];
  for (genvar i = 0; i < axi_pkg::num_spill_regs(NUM_STAGES_AR); i++) begin : g_ar_stages
    cc_stream_spill_reg #(.data_t(axi_pkg::axi_ar_t), .BYPASS(NUM_STAGES_AR == 0)) u_spill_ar (
      .i_clk, .i_rst_n,
      .i_valid(ar_valid[i]),   .i_data(ar_data[i]),   .o_ready(ar_ready[i]),
      .o_valid(ar_valid[i+1]), .o_data(ar_data[i+1]), .i_ready(ar_ready[i+1])
    );
  end
  assign o_m_ar      = ar_data[axi_pkg::num_spill_regs(NUM_STAGES_AR)];
  assign o_m_arvalid = ar_valid[axi_pkg::num_spill_regs(NUM_STAGES_AR)];
  assign ar_ready[axi_pkg::num_spill_regs(NUM_STAGES_AR)] = i_m_arready;

  // Responses run manager to subordinate
  assign b_data[0]  = i_m_b;
  assign b_valid[0] = i_m_bvalid;
  assign o_m_bready = b_ready[0];
  for (genvar i = 0; i < axi_pkg::num_spill_regs(NUM_STAGES_B); i++) begin : g_b_stages
    cc_stream_spill_reg #(.data_t(axi_pkg::axi_b_t), .BYPASS(NUM_STAGES_B == 0)) u_spill_b (
      .i_clk, .i_rst_n,
      .i_valid(b_valid[i]),   .i_data(b_data[i]),   .o_ready(b_ready[i]),
      .o_valid(b_valid[i+1]), .o_data(b_data[i+1]), .i_ready(b_ready[i+1])
    );
  end
  assign o_s_b      = b_data[axi_pkg::num_spill_regs(NUM_STAGES_B)];
  assign o_s_bvalid = b_valid[axi_pkg::num_spill_regs(NUM_STAGES_B)];
  assign b_ready[axi_pkg::num_spill_regs(NUM_STAGES_B)] = i_s_bready;

  assign r_data[0]  = i_m_r;
  assign r_valid[0] = i_m_rvalid;
  assign o_m_rready = r_ready[0];
  for (genvar i = 0; i < axi_pkg::num_spill_regs(NUM_STAGES_R); i++) begin : g_r_stages
    cc_stream_spill_reg #(.data_t(axi_pkg::axi_r_t), .BYPASS(NUM_STAGES_R == 0)) u_spill_r (
      .i_clk, .i_rst_n,
      .i_valid(r_valid[i]),   .i_data(r_data[i]),   .o_ready(r_ready[i]),
      .o_valid(r_valid[i+1]), .o_data(r_data[i+1]), .i_ready(r_ready[i+1])
    );
  end
  assign o_s_r      = r_data[axi_pkg::num_spill_regs(NUM_STAGES_R)];
  assign o_s_rvalid = r_valid[axi_pkg::num_spill_regs(NUM_STAGES_R)];
  assign r_ready[axi_pkg::num_spill_regs(NUM_STAGES_R)] = i_s_rready;

endmodule

//--- design/cc_stream_spill_reg.sv
`timescale 1ns/100ps

module cc_stream_spill_reg #(
  parameter type data_t = logic,
  parameter bit  BYPASS = 1'b0
) (
  input  wire   i_clk,
  input  wire   i_rst_n,
  input  logic  i_valid,
  input  data_t i_data,
  output logic  o_ready,
  output logic  o_valid,
  output data_t o_data,
  input  logic  i_ready
);

  if (BYPASS) begin : g_bypass
    assign o_valid = i_valid;
    assign o_data  = i_data;
    assign o_ready = i_ready;
  end else begin : g_spill
    data_t a_data;
    data_t b_data;
    logic  a_full;
    logic  b_full;
    logic  a_fill;
    logic  a_drain;
    logic  b_fill;
    logic  b_drain;

    assign a_fill  = i_valid & o_ready;
    // Main entry empties whenever the spill entry is free
    assign a_drain = a_full & ~b_full;
    assign b_fill  = a_drain & ~i_ready;
    assign b_drain = b_full & i_ready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        a_full <= 1'b0;
        b_full <= 1'b0;
      end else begin
        a_full <= a_fill | (a_full & ~a_drain);
        b_full <= b_fill | (b_full & ~b_drain);
      end
    end

    always_ff @(posedge i_clk) begin
      if (a_fill) a_data <= i_data;
      if (b_fill) b_data <= a_data;
    end

    // Spill entry holds the older item
    assign o_valid = a_full | b_full;
    assign o_data  = b_full ? b_data : a_data;
    assign o_ready = ~a_full | ~b_full;
  end

endmodule

//--- design/axi_pkg.sv
package axi_pkg;

  localparam int unsigned MEM_WORDS          = 256;
  localparam int unsigned NUM_STAGES_DEFAULT = 2;

  typedef logic [3:0]  axi_id_t;
  typedef logic [15:0] axi_addr_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [63:0] axi_data_t;
  typedef logic [7:0]  axi_strb_t;

  // Bytes per beat as log2
  typedef enum logic [2:0] {
    SIZE_1B, SIZE_2B, SIZE_4B, SIZE_8B, SIZE_16B, SIZE_32B, SIZE_64B, SIZE_128B
  } axi_size_e;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axi_resp_e;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_e  size;
    axi_burst_e burst;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_e resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_e resp;
    logic      last;
  } axi_r_t;

  // Memory subordinate FSMs
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} mem_wr_state_e;
  typedef enum logic {RD_IDLE, RD_DATA} mem_rd_state_e;

  // Zero stages still needs one stage, set to bypass
  function automatic int unsigned num_spill_regs(input int unsigned num_stages);
    return (num_stages == 0) ? 1 : num_stages;
  endfunction

endpackage
